// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/dcache_pkg.sv
      - logic/dcache_tag_array.sv
      - logic/dcache_refill_ctrl.sv
      - logic/dcache_data_ram.sv
      - logic/dcache_response.sv
      - logic/burst_mem_model.sv
      - logic/dcache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/dcache_checker.sv
      - tests/dcache_tb.sv

// File: build.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_refill_ctrl.sv
logic/dcache_data_ram.sv
logic/dcache_response.sv
logic/burst_mem_model.sv
logic/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DCACHE_WAYS 4

// sets, selected by address bits 9:6
`define DCACHE_SETS 16

// tag is address bits 31:10
`define DCACHE_TAG_W 22

// one data RAM row holds a quarter line
`define DCACHE_ROW_W 128

// 32-bit beats per 64-byte line
`define DCACHE_BURST_BEATS 16

// backing memory depth in 32-bit words
`define MEM_WORDS 4096

// each memory word starts as its word address xor this
`define MEM_PRESET_XOR 32'h3c5a_96e1

`endif

// File: logic/burst_mem_model.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module burst_mem_model (
	input  logic                 clk,
	input  logic                 rst,
	input  dcache_pkg::mem_ar_t  ar,
	output logic                 arready,
	output dcache_pkg::mem_r_t   r,
	input  dcache_pkg::mem_wr_t  wr
);

	localparam int AW    = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`DCACHE_BURST_BEATS);

	logic [31:0]      mem [`MEM_WORDS];
	logic             active;
	logic [AW-1:0]    base;
	logic [CNT_W-1:0] cnt;
	logic [AW-1:0]    wr_lo;
	logic [AW-1:0]    wr_hi;

	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = i ^ `MEM_PRESET_XOR;
		end
	end

	// one burst at a time
	assign arready = !active;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
			if (r.last) begin
				active <= 1'b0;
			end
		end else if (ar.valid) begin
			active <= 1'b1;
			cnt    <= '0;
		end
	end

	// burst start, aliased into the word array
	always_ff @(posedge clk) begin
		if (ar.valid && arready) begin
			base <= ar.addr[AW+1:2];
		end
	end

	always_comb begin
		r.valid = active;
		r.data  = mem[base + AW'(cnt)];
		r.last  = active && (cnt == CNT_W'(`DCACHE_BURST_BEATS - 1));
	end

	// a doubleword spans two adjacent words
	assign wr_lo = {wr.addr[AW+1:3], 1'b0};
	assign wr_hi = {wr.addr[AW+1:3], 1'b1};

	always @(posedge clk) begin
		if (wr.en) begin
			mem[wr_lo] <= (mem[wr_lo] & ~wr.mask[31:0]) | (wr.data[31:0] & wr.mask[31:0]);
			mem[wr_hi] <= (mem[wr_hi] & ~wr.mask[63:32]) | (wr.data[63:32] & wr.mask[63:32]);
		end
	end

endmodule

// File: logic/dcache_data_ram.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_data_ram (
	input  logic                       clk,
	input  logic                       en,
	input  logic [5:0]                 row,
	input  dcache_pkg::dcache_fill_t   fill,
	output dcache_pkg::dcache_row_t    dout
);

	// rows per line times sets
	localparam int DEPTH = `DCACHE_SETS * `DCACHE_BURST_BEATS * 32 / `DCACHE_ROW_W;

	dcache_pkg::dcache_row_t mem [DEPTH];

	// single port, so a fill beat takes the cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (fill.en) begin
				mem[fill.row].beat[fill.lane] <= fill.data;
			end else begin
				dout <= mem[row];
			end
		end
	end

endmodule

// File: logic/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0]          tag;
		logic [$clog2(`DCACHE_SETS)-1:0]   index;
		logic [1:0]                        row;
		logic                              dword;
		logic [2:0]                        boff;
	} dcache_addr_t;

	typedef struct packed {
		logic         valid;
		logic         wren;
		dcache_addr_t addr;
		logic [63:0]  wdata;
		logic [63:0]  mask;
	} dcache_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} mem_ar_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic        last;
	} mem_r_t;

	typedef struct packed {
		logic        en;
		logic [31:0] addr;
		logic [63:0] data;
		logic [63:0] mask;
	} mem_wr_t;

	// one refill beat headed for a data RAM
	typedef struct packed {
		logic                     en;
		logic [`DCACHE_WAYS-1:0]  way;
		logic [5:0]               row;
		logic [1:0]               lane;
		logic [31:0]              data;
	} dcache_fill_t;

	typedef struct packed {
		logic                     valid;
		logic [`DCACHE_WAYS-1:0]  way;
		logic                     dword;
		logic                     is_write;
	} dcache_serve_t;

	// beats on refill, doublewords on read-out
	typedef union packed {
		logic [`DCACHE_ROW_W/32-1:0][31:0] beat;
		logic [`DCACHE_ROW_W/64-1:0][63:0] dword;
	} dcache_row_t;

endpackage

// File: logic/dcache_refill_ctrl.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_refill_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  dcache_pkg::dcache_req_t     req,
	input  logic                        ready,
	input  logic [`DCACHE_WAYS-1:0]     hit,
	output dcache_pkg::mem_ar_t         ar,
	input  logic                        arready,
	input  dcache_pkg::mem_r_t          r,
	output dcache_pkg::mem_wr_t         wr,
	output logic [`DCACHE_WAYS-1:0]     ram_en,
	output logic [5:0]                  ram_row,
	output dcache_pkg::dcache_fill_t    fill,
	output logic                        inval_en,
	output dcache_pkg::dcache_serve_t   serve
);

	localparam int CNT_W = $clog2(`DCACHE_BURST_BEATS);

	typedef enum logic {
		S_IDLE,
		S_REFILL
	} state_t;

	state_t                  state;
	logic [CNT_W-1:0]        beat_cnt;
	logic [`DCACHE_WAYS-1:0] victim;
	logic                    accept;
	logic                    hit_any;

	// ready high means the previous request is being answered
	assign accept  = (state == S_IDLE) && req.valid && !ready;
	assign hit_any = |hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			beat_cnt <= '0;
			victim   <= `DCACHE_WAYS'(1);
		end else begin
			case (state)
				S_IDLE: begin
					beat_cnt <= '0;
					victim   <= {victim[`DCACHE_WAYS-2:0], victim[`DCACHE_WAYS-1]};
					if (ar.valid && arready) begin
						state <= S_REFILL;
					end
				end
				S_REFILL: begin
					if (r.valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (r.last) begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_comb begin
		ar.valid = accept && !req.wren && !hit_any;
		ar.addr  = {req.addr[31:6], 6'b0};

		// write-through in the accepting cycle
		wr.en    = accept && req.wren;
		wr.addr  = req.addr;
		wr.data  = req.wdata;
		wr.mask  = req.mask;
		inval_en = wr.en;

		fill.en   = (state == S_REFILL) && r.valid;
		fill.way  = victim;
		fill.row  = {req.addr.index, beat_cnt[3:2]};
		fill.lane = beat_cnt[1:0];
		fill.data = r.data;

		serve.valid    = accept && (req.wren || hit_any);
		serve.way      = (accept && !req.wren) ? hit : '0;
		serve.dword    = req.addr.dword;
		serve.is_write = req.wren;

		ram_row = {req.addr.index, req.addr.row};
		ram_en  = fill.en ? victim : serve.way;
	end

	// memory is always free when a miss is issued
	a_ar_idle: assert property (@(posedge clk) disable iff (rst)
		ar.valid |-> state == S_IDLE && arready ##1 state == S_REFILL);

	a_fill_onehot: assert property (@(posedge clk) disable iff (rst)
		fill.en |-> $onehot(fill.way));

endmodule

// File: logic/dcache_response.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_response (
	input  logic                        clk,
	input  logic                        rst,
	input  dcache_pkg::dcache_serve_t   serve,
	input  dcache_pkg::dcache_row_t     dout0,
	input  dcache_pkg::dcache_row_t     dout1,
	input  dcache_pkg::dcache_row_t     dout2,
	input  dcache_pkg::dcache_row_t     dout3,
	output logic                        ready,
	output logic [63:0]                 rdata
);

	logic [`DCACHE_WAYS-1:0]  way_q;
	logic                     dword_q;
	logic                     is_write_q;
	dcache_pkg::dcache_row_t  row_sel;

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= serve.valid;
		end
	end

	always_ff @(posedge clk) begin
		way_q      <= serve.way;
		dword_q    <= serve.dword;
		is_write_q <= serve.is_write;
	end

	// RAM output is valid in the ready cycle
	always_comb begin
		case (way_q)
			4'b0001: row_sel = dout0;
			4'b0010: row_sel = dout1;
			4'b0100: row_sel = dout2;
			4'b1000: row_sel = dout3;
			default: row_sel = '0;
		endcase
	end

	assign rdata = is_write_q ? 64'b0 : row_sel.dword[dword_q];

	a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
		ready |=> !ready);

	// a read answer always names exactly one way
	a_read_way: assert property (@(posedge clk) disable iff (rst)
		ready && !is_write_q |-> $onehot(way_q));

endmodule

// File: logic/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tag_array (
	input  logic                       clk,
	input  logic                       rst,
	input  dcache_pkg::dcache_addr_t   lookup,
	input  dcache_pkg::dcache_fill_t   fill,
	input  dcache_pkg::dcache_addr_t   inval,
	input  logic                       inval_en,
	output logic [`DCACHE_WAYS-1:0]    hit
);

	localparam int SET_W = $clog2(`DCACHE_SETS);

	logic [`DCACHE_TAG_W-1:0] tags [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0]  valid_q [`DCACHE_WAYS];
	logic                     fill_last;
	logic [SET_W-1:0]         fill_set;

	// beat 15 lands in the top row, top lane
	assign fill_last = fill.en && (&fill.row[1:0]) && (&fill.lane);
	assign fill_set  = fill.row[5:2];

	// tag comes from the request held during the refill
	always_ff @(posedge clk) begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (fill_last && fill.way[w]) begin
				tags[w][fill_set] <= lookup.tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				if (fill_last && fill.way[w]) begin
					valid_q[w][fill_set] <= 1'b1;
				end
				// drop any way holding the written line
				if (inval_en && tags[w][inval.index] == inval.tag) begin
					valid_q[w][inval.index] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			hit[w] = valid_q[w][lookup.index] && (tags[w][lookup.index] == lookup.tag);
		end
	end

	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit));

	// the held request hits the freshly filled way on re-lookup
	a_refill_hits: assert property (@(posedge clk) disable iff (rst)
		fill_last |=> hit == $past(fill.way));

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top (
	input  logic                     clk,
	input  logic                     rst,
	input  dcache_pkg::dcache_req_t  req,
	output logic                     ready,
	output logic [63:0]              rdata
);

	logic [`DCACHE_WAYS-1:0]    hit;
	dcache_pkg::mem_ar_t        ar;
	logic                       arready;
	dcache_pkg::mem_r_t         r;
	dcache_pkg::mem_wr_t        wr;
	logic [`DCACHE_WAYS-1:0]    ram_en;
	logic [5:0]                 ram_row;
	dcache_pkg::dcache_fill_t   fill;
	logic                       inval_en;
	dcache_pkg::dcache_serve_t  serve;
	dcache_pkg::dcache_row_t    dout [`DCACHE_WAYS];

	dcache_tag_array u_tags (
		.clk      (clk),
		.rst      (rst),
		.lookup   (req.addr),
		.fill     (fill),
		.inval    (req.addr),
		.inval_en (inval_en),
		.hit      (hit)
	);

	dcache_refill_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.ready    (ready),
		.hit      (hit),
		.ar       (ar),
		.arready  (arready),
		.r        (r),
		.wr       (wr),
		.ram_en   (ram_en),
		.ram_row  (ram_row),
		.fill     (fill),
		.inval_en (inval_en),
		.serve    (serve)
	);

	// one data RAM per way
	for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_way
		dcache_data_ram u_ram (
			.clk  (clk),
			.en   (ram_en[w]),
			.row  (ram_row),
			.fill (fill),
			.dout (dout[w])
		);
	end

	dcache_response u_resp (
		.clk   (clk),
		.rst   (rst),
		.serve (serve),
		.dout0 (dout[0]),
		.dout1 (dout[1]),
		.dout2 (dout[2]),
		.dout3 (dout[3]),
		.ready (ready),
		.rdata (rdata)
	);

	burst_mem_model u_mem (
		.clk     (clk),
		.rst     (rst),
		.ar      (ar),
		.arready (arready),
		.r       (r),
		.wr      (wr)
	);

endmodule

// File: tests/dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_checker (
	input  logic                     clk,
	input  logic                     rst,
	input  dcache_pkg::dcache_req_t  req,
	input  logic                     ready,
	input  logic [63:0]              rdata,
	input  logic [1:0]               lat_mode,
	output int                       errors
);

	localparam logic [1:0] LAT_HIT  = 2'd1;
	localparam logic [1:0] LAT_MISS = 2'd2;

	logic [31:0]             shadow [`MEM_WORDS];
	dcache_pkg::dcache_req_t cur;
	logic [1:0]              cur_mode;
	logic                    pending;
	int                      cycle;
	int                      start_cycle;
	int                      checks;
	int                      test_checks;
	int                      test_errors;

	// same starting contents as the backing memory
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			shadow[i] = i ^ `MEM_PRESET_XOR;
		end
		pending     = 1'b0;
		cycle       = 0;
		checks      = 0;
		errors      = 0;
		test_checks = 0;
		test_errors = 0;
	end

	// a doubleword is two words, addresses wrap over the memory depth
	function automatic logic [63:0] expected_dword(input logic [31:0] addr);
		int lo;
		lo = ((addr / 4) % `MEM_WORDS) & ~1;
		return {shadow[lo + 1], shadow[lo]};
	endfunction

	task automatic apply_write(input logic [31:0] addr, input logic [63:0] data,
			input logic [63:0] mask);
		int lo;
		lo = ((addr / 4) % `MEM_WORDS) & ~1;
		shadow[lo]     = (shadow[lo] & ~mask[31:0]) | (data[31:0] & mask[31:0]);
		shadow[lo + 1] = (shadow[lo + 1] & ~mask[63:32]) | (data[63:32] & mask[63:32]);
	endtask

	task automatic record_error(input bit wrong_value, input string msg);
		if (wrong_value) begin
			$display("FAILED at time %0t: %s", $time, msg);
		end else begin
			$display("error at time %0t: %s", $time, msg);
		end
		errors++;
		test_errors++;
	endtask

	task automatic test_summary(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic final_summary();
		$display("all tests: %0d checks, %0d errors", checks, errors);
	endtask

	// sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		int          latency;
		logic [63:0] expected;
		cycle++;
		if (!rst) begin
			if (ready) begin
				if (!pending) begin
					record_error(1'b0, "ready pulsed with no request outstanding");
				end else begin
					latency = cycle - start_cycle;
					checks++;
					test_checks++;
					if (cur.wren) begin
						apply_write(cur.addr, cur.wdata, cur.mask);
						if (latency != 1) begin
							record_error(1'b0, $sformatf("write to 0x%08h answered after %0d cycles",
								cur.addr, latency));
						end
					end else begin
						expected = expected_dword(cur.addr);
						if (rdata !== expected) begin
							record_error(1'b1, $sformatf("read 0x%08h returned 0x%016h, expected 0x%016h",
								cur.addr, rdata, expected));
						end
						if (cur_mode == LAT_HIT && latency != 1) begin
							record_error(1'b0, $sformatf("hit on 0x%08h took %0d cycles instead of one",
								cur.addr, latency));
						end
						if (cur_mode == LAT_MISS && latency < 2) begin
							record_error(1'b0, $sformatf("miss on 0x%08h answered too soon",
								cur.addr));
						end
					end
					pending = 1'b0;
				end
			end else if (req.valid && !pending) begin
				pending     = 1'b1;
				cur         = req;
				cur_mode    = lat_mode;
				start_cycle = cycle;
			end
		end
	end

endmodule

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

	localparam logic [1:0] LAT_ANY  = 2'd0;
	localparam logic [1:0] LAT_HIT  = 2'd1;
	localparam logic [1:0] LAT_MISS = 2'd2;

	// up to 40 cycles for each request of the five tests
	localparam int N_REQ       = 4 + 9 + 6 + 10 + 200;
	localparam int WATCHDOG_NS = N_REQ * 40 * 20 + 2000;

	logic                    clk;
	logic                    rst;
	dcache_pkg::dcache_req_t req;
	logic                    ready;
	logic [63:0]             rdata;
	logic [1:0]              lat_mode;
	int                      errors;
	integer                  seed;

	dcache_top uut (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.ready (ready),
		.rdata (rdata)
	);

	dcache_checker chk (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.ready    (ready),
		.rdata    (rdata),
		.lat_mode (lat_mode),
		.errors   (errors)
	);

	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

	// hold the request until ready and drop it for one cycle
	task automatic issue(input logic wren, input logic [31:0] addr, input logic [63:0] wdata,
			input logic [63:0] mask, input logic [1:0] mode);
		@(posedge clk);
		#1;
		req.valid = 1'b1;
		req.wren  = wren;
		req.addr  = addr;
		req.wdata = wdata;
		req.mask  = mask;
		lat_mode  = mode;
		@(negedge clk);
		while (ready !== 1'b1) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req.valid = 1'b0;
	endtask

	task automatic read_dword(input logic [31:0] addr, input logic [1:0] mode);
		issue(1'b0, addr, 64'h0, 64'h0, mode);
	endtask

	task automatic write_dword(input logic [31:0] addr, input logic [63:0] data,
			input logic [63:0] mask);
		issue(1'b1, addr, data, mask, LAT_HIT);
	endtask

	initial begin
		logic [31:0] addr;
		logic [63:0] data;
		logic [63:0] mask;
		seed     = 90115;
		req      = '0;
		lat_mode = LAT_ANY;
		rst      = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// cold lines come from the preset memory
		// third address has high tag bits and wraps over the memory depth
		read_dword(32'h0000_0040, LAT_MISS);
		read_dword(32'h0000_1238, LAT_MISS);
		read_dword(32'hc3a0_2f00, LAT_MISS);
		read_dword(32'h0000_0a08, LAT_MISS);
		chk.test_summary("1 reads after reset");

		// every doubleword of a freshly filled line
		read_dword(32'h0000_0c80, LAT_MISS);
		for (int i = 0; i < 8; i++) begin
			read_dword(32'h0000_0c80 + i * 8, LAT_HIT);
		end
		chk.test_summary("2 hits after refill");

		// each write invalidates the line and the read refetches the merged data
		write_dword(32'h0000_0c98, 64'h0123_4567_89ab_cdef, 64'h00ff_ff00_0000_ffff);
		read_dword(32'h0000_0c98, LAT_MISS);
		write_dword(32'h0005_3a10, 64'hfeed_face_dead_beef, 64'hffff_0000_ff00_00ff);
		read_dword(32'h0005_3a10, LAT_MISS);
		write_dword(32'h0000_0c98, 64'haaaa_5555_aaaa_5555, 64'hf0f0_f0f0_0f0f_0f0f);
		read_dword(32'h0000_0c98, LAT_MISS);
		chk.test_summary("3 masked writes");

		// five lines in set 5 overflow its four ways
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < 5; i++) begin
				read_dword(32'h0000_0140 + i * 32'h400 + pass * 8, LAT_ANY);
			end
		end
		chk.test_summary("4 evictions in one set");

		// about one write in four over an 8 KB window
		for (int i = 0; i < 200; i++) begin
			addr = $random(seed) & 32'h0000_1ff8;
			data = {$random(seed), $random(seed)};
			mask = {$random(seed), $random(seed)};
			if (($random(seed) & 3) == 0) begin
				write_dword(addr, data, mask);
			end else begin
				read_dword(addr, LAT_ANY);
			end
		end
		chk.test_summary("5 random mix");

		chk.final_summary();
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all requests were answered");
		$display("*** FAILED ***");
		$finish;
	end

endmodule
